//--- dv/muldiv_checker.sv
// ----------------------------------------------------------------------
// watches both channels of the unit, predicts each result from the
// arithmetic rules and checks value, latency and handshake behavior
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module muldiv_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_val,
  input logic                     req_rdy,
  input muldiv_pkg::muldiv_req_t  req,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input muldiv_pkg::muldiv_resp_t resp
);

  // edges from the accept edge to the first edge that samples resp_val
  localparam int latency = muldiv_pkg::iter_count + 2;

  int                       errors = 0;
  int                       checks = 0;
  int                       resp_count = 0;
  logic                     pending = 1'b0;
  logic                     resp_seen = 1'b0;
  logic                     idle_checked = 1'b0;
  int                       cycles = 0;
  muldiv_pkg::muldiv_req_t  cur_req;
  muldiv_pkg::muldiv_resp_t expected;

  function automatic string op_name(input muldiv_pkg::muldiv_op_e op);
    case (op)
      muldiv_pkg::op_mul:  return "mul";
      muldiv_pkg::op_mulu: return "mulu";
      muldiv_pkg::op_div:  return "div";
      default:             return "divu";
    endcase
  endfunction

  // expected {hi, lo} for one request
  function automatic muldiv_pkg::muldiv_resp_t ref_result(
    input muldiv_pkg::muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        prod;
    logic [31:0]        ma;
    logic [31:0]        mb;
    logic [31:0]        q;
    logic [31:0]        r;
    logic               na;
    logic               nb;
    if (op == muldiv_pkg::op_mulu) begin
      prod = {32'b0, a} * {32'b0, b};
      return prod;
    end
    if (op == muldiv_pkg::op_mul) begin
      sa   = {{32{a[31]}}, a};
      sb   = {{32{b[31]}}, b};
      prod = sa * sb;
      return prod;
    end
    // divide on magnitudes, signs only matter for op_div
    na = (op == muldiv_pkg::op_div) && a[31];
    nb = (op == muldiv_pkg::op_div) && b[31];
    ma = na ? -a : a;
    mb = nb ? -b : b;
    if (mb == 32'd0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (na ^ nb) q = -q;
    if (na) r = -r;
    return {r, q};
  endfunction

  always @(posedge clk) begin
    if (!reset) begin
      // idle state right after reset
      if (!idle_checked) begin
        idle_checked = 1'b1;
        if (!req_rdy || resp_val) begin
          $display("error %0t: after reset req_rdy=%b resp_val=%b", $time, req_rdy, resp_val);
          errors++;
        end
      end
      if (pending) begin
        cycles++;
        if (req_rdy) begin
          $display("error %0t: req_rdy high while a request is in flight", $time);
          errors++;
        end
        if (resp_val && !resp_seen) begin
          resp_seen = 1'b1;
          checks++;
          if (cycles != latency) begin
            $display("error %0t: %s latency expected %0d got %0d",
                     $time, op_name(cur_req.op), latency, cycles);
            errors++;
          end
        end
        if (resp_val && resp_rdy) begin
          checks++;
          resp_count++;
          pending = 1'b0;
          if (resp !== expected) begin
            $display("error %0t: %s a=%h b=%h expected %h got %h", $time,
                     op_name(cur_req.op), cur_req.a, cur_req.b, expected, resp);
            errors++;
          end
        end
      end else if (resp_val && resp_rdy) begin
        $display("error %0t: response transferred with no request outstanding", $time);
        errors++;
        resp_count++;
      end
      // capture on the accept edge
      if (req_val && req_rdy) begin
        if (pending) begin
          $display("error %0t: request accepted while a response is pending", $time);
          errors++;
        end
        cur_req   = req;
        expected  = ref_result(req.op, req.a, req.b);
        pending   = 1'b1;
        resp_seen = 1'b0;
        cycles    = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/muldiv_props.sv
// ----------------------------------------------------------------------
// handshake and engine exclusion assertions bound into muldiv_unit
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module muldiv_props (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_rdy,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input muldiv_pkg::muldiv_resp_t resp,
  input logic                     mul_busy,
  input logic                     div_busy
);

  // assertion failures so far
  int fail_count = 0;

  // stalled response keeps valid and payload
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else begin
      fail_count++;
      $error("response dropped or changed while stalled");
    end

  // one operation in flight
  busy_excl: assert property (@(posedge clk) disable iff (reset)
    !(mul_busy && div_busy))
    else begin
      fail_count++;
      $error("both engines busy");
    end

  // transfer frees the unit on the next cycle
  rdy_return: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |=> (req_rdy && !resp_val))
    else begin
      fail_count++;
      $error("req_rdy not restored or response repeated after transfer");
    end

endmodule

`default_nettype wire

//--- dv/muldiv_tb.sv
// ----------------------------------------------------------------------
// testbench top for the multiply/divide unit with reset, directed corner
// operands, random requests under response back-pressure and a watchdog
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

  localparam int n_corner   = 6;
  localparam int n_directed = n_corner * n_corner * 4;
  localparam int n_random   = 500;
  localparam int n_tests    = n_directed + n_random;
  localparam int clk_ns     = 100;
  // worst case per test stays well under 45 cycles
  localparam int timeout_ns = (n_tests * 45 + 100) * clk_ns;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  muldiv_pkg::muldiv_req_t  req;
  logic                     resp_val;
  logic                     resp_rdy;
  muldiv_pkg::muldiv_resp_t resp;

  int                       seed;
  int                       tb_errors;
  muldiv_pkg::muldiv_req_t  tests [n_tests];
  // response stall per transfer in cycles
  int                       stall [n_tests];
  logic [31:0]              corners [n_corner];

  tb_clock clock_i (
    .clk (clk)
  );

  muldiv_unit dut_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  muldiv_checker checker_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // protocol assertions attached inside the DUT
  bind muldiv_unit muldiv_props props_i (
    .clk      (clk),
    .reset    (reset),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp),
    .mul_busy (mul_busy),
    .div_busy (div_busy)
  );

  // present one request and hold it until the accept edge
  task automatic send_req(input muldiv_pkg::muldiv_req_t r);
    req_val = 1'b1;
    req     = r;
    do @(posedge clk); while (!req_rdy);
    #10;
  endtask

  // ----------------------------------------------------------------------
  // build the test list, run reset, then issue every request
  // ----------------------------------------------------------------------
  initial begin : main_seq
    logic [31:0] r;
    int          k;
    int          total;
    reset     = 1'b1;
    req_val   = 1'b0;
    req       = '0;
    resp_rdy  = 1'b0;
    tb_errors = 0;
    seed      = 32'h3c736323;
    // zero, one, all ones, most negative, small positive and negative
    corners[0] = 32'h00000000;
    corners[1] = 32'h00000001;
    corners[2] = 32'hffffffff;
    corners[3] = 32'h80000000;
    corners[4] = 32'h00000007;
    corners[5] = 32'hfffffff9;
    k = 0;
    for (int op = 0; op < 4; op++) begin
      for (int ia = 0; ia < n_corner; ia++) begin
        for (int ib = 0; ib < n_corner; ib++) begin
          tests[k].op = muldiv_pkg::muldiv_op_e'(2'(op));
          tests[k].a  = corners[ia];
          tests[k].b  = corners[ib];
          k++;
        end
      end
    end
    for (int i = 0; i < n_random; i++) begin
      r = $random(seed);
      tests[k].op = muldiv_pkg::muldiv_op_e'(r[1:0]);
      tests[k].a  = $random(seed);
      tests[k].b  = $random(seed);
      // shrink some divisors so quotients get interesting
      if (i % 2 == 1) begin
        tests[k].b = tests[k].b >> r[6:2];
      end
      k++;
    end
    for (int i = 0; i < n_tests; i++) begin
      r = $random(seed);
      stall[i] = r % 6;
    end
    // a zero stall has ready waiting before the response shows up
    resp_rdy = (stall[0] == 0);

    repeat (16) @(posedge clk);
    #10 reset = 1'b0;
    // one idle edge for the post-reset check
    @(posedge clk);
    #10;
    for (int i = 0; i < n_tests; i++) begin
      send_req(tests[i]);
    end
    req_val = 1'b0;

    while (checker_i.resp_count < n_tests) @(posedge clk);
    repeat (2) @(posedge clk);
    if (checker_i.resp_count != n_tests) begin
      $display("response count %0d does not match %0d requests",
               checker_i.resp_count, n_tests);
      tb_errors++;
    end
    total = checker_i.errors + tb_errors + dut_i.props_i.fail_count;
    $display("errors: %0d, checks: %0d", total, checker_i.checks);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ----------------------------------------------------------------------
  // response side withholds resp_rdy a random number of cycles
  // ----------------------------------------------------------------------
  initial begin : resp_drive
    int idx;
    idx = 0;
    forever begin
      @(posedge clk);
      if (resp_val && !reset) begin
        // ready low here means a stall of at least one cycle
        if (!resp_rdy) begin
          repeat (stall[idx % n_tests] - 1) @(posedge clk);
          #10 resp_rdy = 1'b1;
          @(posedge clk);
        end
        // the response moved on this edge
        #10 resp_rdy = (stall[(idx + 1) % n_tests] == 0);
        idx++;
      end
    end
  end

  // hang guard
  initial begin : watchdog
    #(timeout_ns);
    $display("watchdog: run did not finish within %0d ns, the DUT appears hung",
             timeout_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// ----------------------------------------------------------------------
// free-running testbench clock, 100 ns period
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // half of the 100 ns period
  localparam int half_ns = 50;

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- flist.f
src/muldiv_pkg.sv
src/div_dpath.sv
src/div_ctrl.sv
src/mul_iterative.sv
src/muldiv_unit.sv
dv/tb_clock.sv
dv/muldiv_checker.sv
dv/muldiv_props.sv
dv/muldiv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module muldiv_tb -f flist.f

# keep going past assertion errors so the testbench reaches its summary
./obj_dir/Vmuldiv_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: FAIL"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "run.sh: simulation ended without a result line"
  exit 1
fi
echo "run.sh: PASS"

//--- src/div_ctrl.sv
// ----------------------------------------------------------------------
// divider FSM: load, iterate for iter_count cycles, fix-up, hold done
// until the response is taken
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module div_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  ack,
  output logic                  busy,
  output logic                  done,
  output muldiv_pkg::div_ctrl_t ctrl
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } div_state_e;

  div_state_e state;
  logic [5:0] count;

  // ----------------------------------------------------------------------
  // state and iteration counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= 6'd0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
            count <= 6'd0;
          end
        end
        st_calc: begin
          // last step leaves for fix-up
          if (count == 6'(muldiv_pkg::iter_count - 1)) begin
            state <= st_fix;
          end else begin
            count <= count + 6'd1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // result held until the top level takes it
          if (ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath controls
  // ----------------------------------------------------------------------
  always_comb begin
    ctrl = '0;
    case (state)
      st_idle: begin
        // operands captured on the accept edge
        ctrl.a_en = start;
        ctrl.b_en = start;
      end
      st_calc: begin
        ctrl.a_en    = 1'b1;
        ctrl.a_sel   = 1'b1;
        ctrl.sub_sel = 1'b1;
      end
      st_fix: ctrl.fix_en = 1'b1;
      default: ctrl = '0;
    endcase
  end

  assign busy = (state == st_calc) || (state == st_fix);
  assign done = (state == st_done);

endmodule

`default_nettype wire

//--- src/div_dpath.sv
// ----------------------------------------------------------------------
// restoring divider datapath steered cycle by cycle by div_ctrl
// remainder ends in the upper half of the result, quotient in the lower
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module div_dpath (
  input  logic                    clk,
  input  logic                    reset,
  input  muldiv_pkg::muldiv_req_t req,
  input  muldiv_pkg::div_ctrl_t   ctrl,
  output muldiv_pkg::muldiv_resp_t result
);

  // ----------------------------------------------------------------------
  // operand magnitudes from the request
  // ----------------------------------------------------------------------

  logic                          req_signed;
  logic                          req_neg_a;
  logic                          req_neg_b;
  logic [muldiv_pkg::xlen-1:0]   mag_a;
  logic [muldiv_pkg::xlen-1:0]   mag_b;

  // only op_div treats operands as two's complement
  assign req_signed = (req.op == muldiv_pkg::op_div);
  assign req_neg_a  = req_signed & req.a[muldiv_pkg::xlen-1];
  assign req_neg_b  = req_signed & req.b[muldiv_pkg::xlen-1];

  assign mag_a = req_neg_a ? -req.a : req.a;
  assign mag_b = req_neg_b ? -req.b : req.b;

  // ----------------------------------------------------------------------
  // working registers
  // ----------------------------------------------------------------------

  // sign info kept for the fix-up step
  logic                          neg_a;
  logic                          neg_b;

  // remainder and quotient working value with one spare bit on top
  logic [2*muldiv_pkg::xlen:0]   a_reg;
  // divisor aligned to the remainder half
  logic [2*muldiv_pkg::xlen:0]   b_reg;

  logic [2*muldiv_pkg::xlen:0]   init_a;
  logic [2*muldiv_pkg::xlen:0]   init_b;
  logic [2*muldiv_pkg::xlen:0]   a_shift;
  logic [2*muldiv_pkg::xlen:0]   trial_diff;
  logic [2*muldiv_pkg::xlen:0]   iter_next;
  logic [2*muldiv_pkg::xlen:0]   a_next;

  logic [muldiv_pkg::xlen-1:0]   quot_raw;
  logic [muldiv_pkg::xlen-1:0]   rem_raw;
  logic [muldiv_pkg::xlen-1:0]   quot_fix;
  logic [muldiv_pkg::xlen-1:0]   rem_fix;

  // dividend magnitude starts in the quotient half with a zero remainder
  assign init_a = {{(muldiv_pkg::xlen+1){1'b0}}, mag_a};
  assign init_b = {1'b0, mag_b, {muldiv_pkg::xlen{1'b0}}};

  // one restoring step
  assign a_shift    = a_reg << 1;
  assign trial_diff = a_shift - b_reg;

  // top bit clear means the shifted remainder covered the divisor
  always_comb begin
    if (ctrl.sub_sel && !trial_diff[2*muldiv_pkg::xlen]) begin
      iter_next = {trial_diff[2*muldiv_pkg::xlen:1], 1'b1};
    end else begin
      iter_next = a_shift;
    end
  end

  // sign fix-up
  assign quot_raw = a_reg[muldiv_pkg::xlen-1:0];
  assign rem_raw  = a_reg[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];

  // quotient negated when the signs differ
  // remainder takes the sign of the dividend
  assign quot_fix = (neg_a ^ neg_b) ? -quot_raw : quot_raw;
  assign rem_fix  = neg_a ? -rem_raw : rem_raw;

  always_comb begin
    if (ctrl.fix_en) begin
      a_next = {1'b0, rem_fix, quot_fix};
    end else if (ctrl.a_sel) begin
      a_next = iter_next;
    end else begin
      a_next = init_a;
    end
  end

  // operand signs captured at load
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_a <= 1'b0;
      neg_b <= 1'b0;
    end else if (ctrl.b_en) begin
      neg_a <= req_neg_a;
      neg_b <= req_neg_b;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.a_en || ctrl.fix_en) begin
      a_reg <= a_next;
    end
    if (ctrl.b_en) begin
      b_reg <= init_b;
    end
  end

  assign result.hi = a_reg[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
  assign result.lo = a_reg[muldiv_pkg::xlen-1:0];

endmodule

`default_nettype wire

//--- src/mul_iterative.sv
// ----------------------------------------------------------------------
// shift-add multiplier over operand magnitudes with a final sign fix-up
// full 64-bit product held on result until ack
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     ack,
  input  muldiv_pkg::muldiv_req_t  req,
  output logic                     busy,
  output logic                     done,
  output muldiv_pkg::muldiv_resp_t result
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } mul_state_e;

  mul_state_e state;
  logic [5:0] count;

  // ----------------------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------------------
  logic                          req_signed;
  logic                          req_neg_a;
  logic                          req_neg_b;
  logic [muldiv_pkg::xlen-1:0]   mag_a;
  logic [muldiv_pkg::xlen-1:0]   mag_b;

  assign req_signed = (req.op == muldiv_pkg::op_mul);
  assign req_neg_a  = req_signed & req.a[muldiv_pkg::xlen-1];
  assign req_neg_b  = req_signed & req.b[muldiv_pkg::xlen-1];
  assign mag_a      = req_neg_a ? -req.a : req.a;
  assign mag_b      = req_neg_b ? -req.b : req.b;

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------
  logic [2*muldiv_pkg::xlen-1:0] mcand;
  logic [muldiv_pkg::xlen-1:0]   mplier;
  logic [2*muldiv_pkg::xlen-1:0] acc;
  logic                          neg;

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (start) begin
          mcand  <= {{muldiv_pkg::xlen{1'b0}}, mag_a};
          mplier <= mag_b;
          acc    <= '0;
          neg    <= req_neg_a ^ req_neg_b;
        end
      end
      st_calc: begin
        // add the shifted multiplicand for each set multiplier bit
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      st_fix: begin
        if (neg) begin
          acc <= -acc;
        end
      end
      default: acc <= acc;
    endcase
  end

  // ----------------------------------------------------------------------
  // controller
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= 6'd0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
            count <= 6'd0;
          end
        end
        st_calc: begin
          if (count == 6'(muldiv_pkg::iter_count - 1)) begin
            state <= st_fix;
          end else begin
            count <= count + 6'd1;
          end
        end
        st_fix:  state <= st_done;
        st_done: begin
          if (ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy   = (state == st_calc) || (state == st_fix);
  assign done   = (state == st_done);
  assign result = acc;

endmodule

`default_nettype wire

//--- src/muldiv_pkg.sv
// ----------------------------------------------------------------------
// shared types for the multiply/divide unit: operation codes, request
// and response payloads, and the divider control bundle
// ----------------------------------------------------------------------
`default_nettype none

package muldiv_pkg;

  // operand width, fixed for the whole unit
  parameter int xlen = 32;
  // one shift/add or shift/subtract step per operand bit
  parameter int iter_count = xlen;

  // ----------------------------------------------------------------------
  // operation codes
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // request payload, 66 bits
  // a is the multiplicand or dividend, b the multiplier or divisor
  typedef struct packed {
    muldiv_op_e        op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
  } muldiv_req_t;

  // response payload, 64 bits
  // hi carries upper product or remainder, lo lower product or quotient
  typedef struct packed {
    logic [xlen-1:0]   hi;
    logic [xlen-1:0]   lo;
  } muldiv_resp_t;

  // divider FSM to datapath control bundle
  typedef struct packed {
    logic a_en;
    logic b_en;
    logic a_sel;
    logic sub_sel;
    logic fix_en;
  } div_ctrl_t;

endpackage

`default_nettype wire

//--- src/muldiv_unit.sv
// ----------------------------------------------------------------------
// multiply/divide unit top: one request in flight, valid/ready on the
// request and response channels, steers work to the mul or div engine
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
  input  logic                     clk,
  input  logic                     reset,
  // request channel
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_pkg::muldiv_req_t  req,
  // response channel
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t resp
);

  // ----------------------------------------------------------------------
  // engine handshakes
  // ----------------------------------------------------------------------
  logic                     accept;
  logic                     is_mul;
  logic                     ack;

  logic                     mul_start;
  logic                     mul_busy;
  logic                     mul_done;
  muldiv_pkg::muldiv_resp_t mul_result;

  logic                     div_start;
  logic                     div_busy;
  logic                     div_done;
  muldiv_pkg::muldiv_resp_t div_result;
  muldiv_pkg::div_ctrl_t    div_ctl;

  // both multiply codes go to the multiplier
  assign is_mul = (req.op == muldiv_pkg::op_mul) || (req.op == muldiv_pkg::op_mulu);

  // idle engines and nothing waiting on the response side
  assign req_rdy = !mul_busy && !div_busy && !mul_done && !div_done;
  assign accept  = req_val && req_rdy;

  // exactly one engine started per accepted request
  assign mul_start = accept && is_mul;
  assign div_start = accept && !is_mul;

  // response merge, at most one engine is ever done
  assign resp_val = mul_done || div_done;
  assign resp     = mul_done ? mul_result : div_result;
  assign ack      = resp_val && resp_rdy;

  // ----------------------------------------------------------------------
  // engines
  // ----------------------------------------------------------------------
  mul_iterative mul_i (
    .clk    (clk),
    .reset  (reset),
    .start  (mul_start),
    .ack    (ack),
    .req    (req),
    .busy   (mul_busy),
    .done   (mul_done),
    .result (mul_result)
  );

  div_ctrl div_ctrl_i (
    .clk   (clk),
    .reset (reset),
    .start (div_start),
    .ack   (ack),
    .busy  (div_busy),
    .done  (div_done),
    .ctrl  (div_ctl)
  );

  div_dpath div_dpath_i (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ctrl   (div_ctl),
    .result (div_result)
  );

endmodule

`default_nettype wire
